// File: lcd_i2c.f
+incdir+verilog
verilog/lcd_i2c_pkg.sv
verilog/lcd_wb_regs.sv
verilog/lcd_sequencer.sv
verilog/i2c_byte_master.sv
verilog/lcd_i2c_top.sv
bench/i2c_target_model.sv
bench/lcd_i2c_checker.sv
bench/lcd_i2c_tb.sv

// File: bench/lcd_i2c_tb.sv
`timescale 1ns/1ps
`include "lcd_i2c_config.svh"

module lcd_i2c_tb;

    localparam int    N_REQ     = 13;
    localparam int    ACK_LIMIT = 4000;
    localparam longint WATCHDOG_NS = N_REQ * 2 * 50 * 4 * `LCD_I2C_CLK_DIV * 8 + 20000;

    logic        clk;
    logic        rst;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        we;
    logic        stb;
    logic        cyc;
    logic        ack;
    logic        scl_oe;
    logic        sda_oe;
    logic        sda_in;
    logic        busy;
    logic        scl;
    logic        sda;
    logic        sda_pull;
    logic [6:0]  model_ack_addr;
    int          model_refuse;
    logic [47:0] exp_q[$];
    logic [31:0] rng_state;
    logic        cur_bl;
    logic [6:0]  cur_addr;
    time         last_ack_t;
    time         busy_fall_t;

    // pull-ups on both lines
    assign scl    = scl_oe ? 1'b0 : 1'b1;
    assign sda    = (sda_oe || sda_pull) ? 1'b0 : 1'b1;
    assign sda_in = sda;

    lcd_i2c_top u_lcd_i2c_top (
        .clk    (clk),
        .rst    (rst),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .we     (we),
        .stb    (stb),
        .cyc    (cyc),
        .ack    (ack),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe),
        .sda_in (sda_in),
        .busy   (busy)
    );

    i2c_target_model u_target (
        .scl        (scl),
        .sda        (sda),
        .ack_addr   (model_ack_addr),
        .refuse_idx (model_refuse),
        .sda_pull   (sda_pull)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(negedge busy) busy_fall_t = $time;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // one transaction of a request, as {count, address byte, four expander bytes}
    function automatic logic [47:0] expected_bytes(input logic [15:0] word, input logic bl,
                                                   input logic [6:0] addr, input int idx);
        logic [7:0] lcd;
        logic       rs;
        logic [31:0] data;
        if (word[15] && idx == 0) begin
            lcd = 8'h80 + (word[8] ? 8'd64 : 8'd0) + {4'd0, word[12:9]};
            rs  = 1'b0;
        end else begin
            lcd = word[7:0];
            rs  = word[15] ? 1'b1 : word[8];
        end
        data = {lcd[7:4], bl, 1'b1, 1'b0, rs, lcd[7:4], bl, 1'b0, 1'b0, rs,
                lcd[3:0], bl, 1'b1, 1'b0, rs, lcd[3:0], bl, 1'b0, 1'b0, rs};
        return {8'd4, addr, 1'b0, data};
    endfunction

    task automatic end_with_failure();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic wait_for_ack();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack && waited < ACK_LIMIT);
        if (!ack) begin
            $display("ERROR at %0t ns: no Wishbone ack for address %0d", $time, adr);
            end_with_failure();
        end
    endtask

    task automatic wb_write(input logic [1:0] a, input logic [31:0] d);
        @(posedge clk);
        #1;
        adr   = a;
        dat_w = d;
        we    = 1'b1;
        stb   = 1'b1;
        cyc   = 1'b1;
        wait_for_ack();
        last_ack_t = $time;
        we  = 1'b0;
        stb = 1'b0;
        cyc = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] a, output logic [31:0] d);
        @(posedge clk);
        #1;
        adr = a;
        we  = 1'b0;
        stb = 1'b1;
        cyc = 1'b1;
        wait_for_ack();
        d   = dat_r;
        stb = 1'b0;
        cyc = 1'b0;
    endtask

    task automatic write_ctrl(input logic [6:0] a, input logic bl);
        cur_addr = a;
        cur_bl   = bl;
        wb_write(`LCD_I2C_REG_CTRL, {17'd0, a, 7'd0, bl});
    endtask

    // queue what the target should see, then post the request
    task automatic issue_request(input logic [15:0] word);
        logic [47:0] rec;
        int          n_txn;
        int          keep;
        n_txn = word[15] ? 2 : 1;
        for (int t = 0; t < n_txn; t++) begin
            rec = expected_bytes(word, cur_bl, cur_addr, t);
            if (cur_addr != model_ack_addr) begin
                exp_q.push_back({8'd0, rec[39:32], 32'd0}); // address refused, rest dropped
                break;
            end else if (model_refuse >= 0 && model_refuse < 4) begin
                keep = model_refuse + 1;
                exp_q.push_back({8'(keep), rec[39:32],
                                 rec[31:0] & ~(32'hffff_ffff >> (8 * keep))});
                break;
            end
            exp_q.push_back(rec);
        end
        wb_write(`LCD_I2C_REG_REQ, {16'd0, word});
    endtask

    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0 || busy) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin : compare_proc
        logic [47:0] got;
        logic [47:0] exp;
        forever begin
            @(posedge clk);
            while (u_target.rec_q.size() > 0) begin
                got = u_target.rec_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t ns: target saw a transaction none was expected", $time);
                    end_with_failure();
                end else begin
                    exp = exp_q.pop_front();
                    check_value({24'd0, got[39:32]}, {24'd0, exp[39:32]}, "address byte");
                    check_value({24'd0, got[47:40]}, {24'd0, exp[47:40]}, "data byte count");
                    check_value(got[31:0], exp[31:0], "expander bytes");
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: simulation did not finish within %0d ns", WATCHDOG_NS);
        end_with_failure();
    end

    initial begin : main_seq
        logic [31:0] rd;
        logic [31:0] rnd;
        time         a_ack_t;
        rst            = 1'b1;
        adr            = 2'd0;
        dat_w          = 32'd0;
        we             = 1'b0;
        stb            = 1'b0;
        cyc            = 1'b0;
        model_ack_addr = `LCD_I2C_DEF_ADDR;
        model_refuse   = -1;
        cur_addr       = `LCD_I2C_DEF_ADDR;
        cur_bl         = 1'b0;
        rng_state      = 32'hbf88_be4d;
        busy_fall_t    = 0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        wb_read(`LCD_I2C_REG_STAT, rd);
        check_value(rd, 32'd0, "STAT after reset");
        wb_read(`LCD_I2C_REG_CTRL, rd);
        check_value(rd, {17'd0, `LCD_I2C_DEF_ADDR, 8'd0}, "CTRL after reset");
        check_value({31'd0, scl}, 32'd1, "idle scl level");
        check_value({31'd0, sda}, 32'd1, "idle sda level");

        issue_request(16'h0028); // raw command, rs 0
        drain();

        write_ctrl(`LCD_I2C_DEF_ADDR, 1'b1);
        for (int i = 0; i < 6; i++) begin
            rnd = next_random();
            issue_request({1'b1, 2'b00, rnd[19:16], i[0], rnd[7:0]});
        end
        rnd = next_random();
        issue_request({1'b0, 6'd0, 1'b1, rnd[7:0]}); // raw data, rs 1
        drain();

        rnd = next_random();
        issue_request({1'b1, 2'b00, rnd[11:8], 1'b1, rnd[7:0]});
        a_ack_t = last_ack_t;
        check_value({31'd0, busy}, 32'd1, "busy after first request");
        issue_request(16'h0001); // stalls until the first is done
        check_value({31'd0, busy_fall_t > a_ack_t}, 32'd1, "busy fell before second ack");
        drain();

        model_refuse = 2;
        rnd = next_random();
        issue_request({1'b1, 2'b00, rnd[11:8], 1'b0, rnd[7:0]});
        drain();
        model_refuse = -1;
        wb_read(`LCD_I2C_REG_STAT, rd);
        check_value(rd, 32'd2, "STAT after refused byte");
        wb_write(`LCD_I2C_REG_STAT, 32'd2);
        wb_read(`LCD_I2C_REG_STAT, rd);
        check_value(rd, 32'd0, "STAT after clear");

        write_ctrl(7'h3f, 1'b1);
        model_ack_addr = 7'h3f;
        issue_request(16'h000c);
        drain();
        write_ctrl(7'h20, 1'b0); // not answered by the target
        rnd = next_random();
        issue_request({1'b1, 2'b00, rnd[11:8], 1'b1, rnd[7:0]});
        drain();
        wb_read(`LCD_I2C_REG_STAT, rd);
        check_value(rd, 32'd2, "STAT after address nack");
        wb_write(`LCD_I2C_REG_STAT, 32'd2);
        wb_read(`LCD_I2C_REG_STAT, rd);
        check_value(rd, 32'd0, "STAT after second clear");

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: bench/lcd_i2c_checker.sv
`timescale 1ns/1ps

module lcd_i2c_checker import lcd_i2c_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       ack,
    input logic       scl_oe,
    input logic       sda_in,
    input logic       busy,
    input logic       txn_start,
    input logic       txn_done,
    input i2c_state_e state
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("wishbone ack held for more than one clock");

    // scl high at both samples means sda moved under a high clock
    sda_scl_high: assert property (@(posedge clk) disable iff (rst)
        ($changed(sda_in) && !scl_oe && !$past(scl_oe))
            |-> (state inside {I2C_START, I2C_STOP}))
        else $error("sda changed while scl high outside start or stop");

    // busy may only overlap an idle engine while a transaction starts or ends
    idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        (state == I2C_IDLE && !txn_start && !txn_done) |-> !busy)
        else $error("busy high while engine idle with no transaction starting or ending");

endmodule

bind lcd_i2c_top lcd_i2c_checker u_lcd_i2c_checker (
    .clk       (clk),
    .rst       (rst),
    .ack       (ack),
    .scl_oe    (scl_oe),
    .sda_in    (sda_in),
    .busy      (busy),
    .txn_start (txn_start),
    .txn_done  (txn_done),
    .state     (u_i2c_byte_master.state)
);

// File: bench/i2c_target_model.sv
`timescale 1ns/1ps

module i2c_target_model (
    input  logic       scl,
    input  logic       sda,
    input  logic [6:0] ack_addr,
    input  int         refuse_idx,
    output logic       sda_pull
);

    logic [47:0] rec_q[$];        // {data byte count, address byte, data bytes}

    logic        in_txn = 1'b0;
    logic        ignore = 1'b0;   // refused byte, wait for stop
    logic        is_addr;
    int          bit_cnt;
    int          nbytes;
    logic [7:0]  shreg;
    logic [7:0]  addr_byte;
    logic [31:0] data;

    initial begin
        sda_pull = 1'b0;
    end

    always @(negedge sda) begin
        if (scl === 1'b1) begin // start
            in_txn    = 1'b1;
            ignore    = 1'b0;
            is_addr   = 1'b1;
            bit_cnt   = 0;
            nbytes    = 0;
            addr_byte = 8'd0;
            data      = 32'd0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_txn) begin // stop
            rec_q.push_back({8'(nbytes), addr_byte, data});
            in_txn = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (in_txn && !ignore && bit_cnt < 8) begin
            shreg   = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    // ack is driven and released only while scl is low
    always @(negedge scl) begin
        if (in_txn && !ignore) begin
            if (bit_cnt == 8) begin
                if (is_addr) begin
                    addr_byte = shreg;
                    sda_pull  = (shreg == {ack_addr, 1'b0});
                end else begin
                    if (nbytes < 4) begin
                        data[8*(3-nbytes) +: 8] = shreg; // first byte on top
                    end
                    sda_pull = (nbytes != refuse_idx);
                    nbytes   = nbytes + 1;
                end
                ignore  = !sda_pull;
                is_addr = 1'b0;
                bit_cnt = 9;
            end else if (bit_cnt == 9) begin
                sda_pull = 1'b0;
                bit_cnt  = 0;
            end
        end
    end

endmodule

// File: verilog/lcd_i2c_top.sv
`timescale 1ns/1ps

module lcd_i2c_top import lcd_i2c_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    input  logic        we,
    input  logic        stb,
    input  logic        cyc,
    output logic        ack,
    output logic        scl_oe,
    output logic        sda_oe,
    input  logic        sda_in,
    output logic        busy
);

    lcd_req_u   req_word;
    logic       req_valid;
    logic       req_ready;
    logic       backlight;
    logic [6:0] target_addr;
    logic       nack_event;
    logic       txn_start;
    logic [7:0] txn_byte;
    logic       txn_last;
    logic       byte_req;
    logic       txn_done;
    logic       nack;

    lcd_wb_regs u_lcd_wb_regs (
        .clk         (clk),
        .rst         (rst),
        .adr         (adr),
        .dat_w       (dat_w),
        .we          (we),
        .stb         (stb),
        .cyc         (cyc),
        .dat_r       (dat_r),
        .ack         (ack),
        .busy        (busy),
        .nack_event  (nack_event),
        .req_valid   (req_valid),
        .req_word    (req_word),
        .backlight   (backlight),
        .target_addr (target_addr),
        .req_ready   (req_ready)
    );

    lcd_sequencer u_lcd_sequencer (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_word   (req_word),
        .backlight  (backlight),
        .req_ready  (req_ready),
        .busy       (busy),
        .txn_start  (txn_start),
        .txn_byte   (txn_byte),
        .txn_last   (txn_last),
        .byte_req   (byte_req),
        .txn_done   (txn_done),
        .nack       (nack),
        .nack_event (nack_event)
    );

    i2c_byte_master u_i2c_byte_master (
        .clk         (clk),
        .rst         (rst),
        .txn_start   (txn_start),
        .target_addr (target_addr),
        .txn_byte    (txn_byte),
        .txn_last    (txn_last),
        .byte_req    (byte_req),
        .txn_done    (txn_done),
        .nack        (nack),
        .scl_oe      (scl_oe),
        .sda_oe      (sda_oe),
        .sda_in      (sda_in)
    );

endmodule

// File: verilog/i2c_byte_master.sv
`timescale 1ns/1ps
`include "lcd_i2c_config.svh"

module i2c_byte_master import lcd_i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       txn_start,
    input  logic [6:0] target_addr,
    input  logic [7:0] txn_byte,
    input  logic       txn_last,
    output logic       byte_req,
    output logic       txn_done,
    output logic       nack,
    output logic       scl_oe,
    output logic       sda_oe,
    input  logic       sda_in
);

    localparam int DIV   = `LCD_I2C_CLK_DIV;
    localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

    i2c_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       q;          // quarter within the scl bit
    logic             tick;
    logic [2:0]       bit_cnt;
    logic [7:0]       shreg;
    logic             last_byte;
    logic             stop_next;
    logic             load_addr;
    logic             load_data;
    logic             shift_en;

    assign tick = (div_cnt == DIV_W'(DIV - 1));

    assign load_addr = (state == I2C_IDLE) && txn_start;
    assign shift_en  = (state == I2C_SHIFT) && tick && (q == 2'd3);
    assign load_data = (state == I2C_ACK) && tick && (q == 2'd3) && !stop_next;

    // sequencer answers on the next clock, well before load_data
    assign byte_req = (state == I2C_ACK) && tick && (q == 2'd2) && !sda_in && !last_byte;

    always_comb begin
        case (state)
            I2C_START:                    scl_oe = (q == 2'd3);
            I2C_SHIFT, I2C_ACK, I2C_STOP: scl_oe = (q < 2'd2); // low half first
            default:                      scl_oe = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= I2C_IDLE;
            div_cnt   <= '0;
            q         <= 2'd0;
            bit_cnt   <= 3'd0;
            sda_oe    <= 1'b0;
            last_byte <= 1'b0;
            stop_next <= 1'b0;
            txn_done  <= 1'b0;
            nack      <= 1'b0;
        end else begin
            txn_done <= 1'b0;
            if (state == I2C_IDLE) begin
                div_cnt <= '0;
                q       <= 2'd0;
                if (txn_start) begin
                    state     <= I2C_START;
                    nack      <= 1'b0;
                    last_byte <= 1'b0;
                    stop_next <= 1'b0;
                end
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    q <= q + 2'd1;
                    case (state)
                        I2C_START: begin
                            if (q == 2'd0) begin
                                sda_oe <= 1'b1; // sda falls while scl high
                            end
                            if (q == 2'd3) begin
                                state   <= I2C_SHIFT;
                                bit_cnt <= 3'd0;
                            end
                        end
                        I2C_SHIFT: begin
                            if (q == 2'd0) begin
                                sda_oe <= ~shreg[7]; // msb first
                            end
                            if (q == 2'd3) begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7) begin
                                    state <= I2C_ACK;
                                end
                            end
                        end
                        I2C_ACK: begin
                            if (q == 2'd0) begin
                                sda_oe <= 1'b0; // target drives ack
                            end
                            if (q == 2'd2) begin
                                nack      <= sda_in;
                                stop_next <= sda_in || last_byte;
                            end
                            if (q == 2'd3) begin
                                if (stop_next) begin
                                    state <= I2C_STOP;
                                end else begin
                                    state     <= I2C_SHIFT;
                                    last_byte <= txn_last;
                                end
                            end
                        end
                        I2C_STOP: begin
                            if (q == 2'd0) begin
                                sda_oe <= 1'b1;
                            end
                            if (q == 2'd2) begin
                                sda_oe <= 1'b0; // sda rises while scl high
                            end
                            if (q == 2'd3) begin
                                state    <= I2C_IDLE;
                                txn_done <= 1'b1;
                            end
                        end
                        default: state <= I2C_IDLE;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_addr) begin
            shreg <= {target_addr, 1'b0}; // write bit
        end else if (load_data) begin
            shreg <= txn_byte;
        end else if (shift_en) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

// File: verilog/lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer import lcd_i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  lcd_req_u   req_word,
    input  logic       backlight,
    output logic       req_ready,
    output logic       busy,
    output logic       txn_start,
    output logic [7:0] txn_byte,
    output logic       txn_last,
    input  logic       byte_req,
    input  logic       txn_done,
    input  logic       nack,
    output logic       nack_event
);

    lcd_req_u   req_q;    // held request
    logic       second;   // character byte of a char request
    logic [1:0] beat;     // expander byte index
    logic [7:0] lcd_byte;
    logic       lcd_rs;
    logic [3:0] nibble;
    logic       accept;
    logic       more;

    assign req_ready  = !busy;
    assign accept     = req_valid && req_ready;
    assign nack_event = txn_done && nack;

    // address command done, character still to send
    assign more = req_q.chr.kind && !second;

    always_comb begin
        if (req_q.chr.kind && !second) begin
            lcd_byte = {1'b1, req_q.chr.line, 2'b00, req_q.chr.column}; // set ddram address
            lcd_rs   = 1'b0;
        end else if (req_q.chr.kind) begin
            lcd_byte = req_q.chr.code;
            lcd_rs   = 1'b1;
        end else begin
            lcd_byte = req_q.raw.data;
            lcd_rs   = req_q.raw.rs;
        end
        nibble = beat[1] ? lcd_byte[3:0] : lcd_byte[7:4]; // high nibble first
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            txn_start <= 1'b0;
            second    <= 1'b0;
        end else begin
            txn_start <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                txn_start <= 1'b1;
                second    <= 1'b0;
            end else if (txn_done) begin
                if (!nack && more) begin
                    second    <= 1'b1;
                    txn_start <= 1'b1;
                end else begin
                    busy <= 1'b0; // done, or rest dropped on nack
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat     <= 2'd0;
            txn_last <= 1'b0;
        end else if (txn_start) begin
            beat     <= 2'd0;
            txn_last <= 1'b0;
        end else if (byte_req) begin
            beat     <= beat + 2'd1;
            txn_last <= (beat == 2'd3);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_word;
        end
        if (byte_req) begin
            // d7..d4, bl, en, rw, rs
            txn_byte <= {nibble, backlight, ~beat[0], 1'b0, lcd_rs};
        end
    end

endmodule

// File: verilog/lcd_wb_regs.sv
`timescale 1ns/1ps
`include "lcd_i2c_config.svh"

module lcd_wb_regs import lcd_i2c_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    input  logic        we,
    input  logic        stb,
    input  logic        cyc,
    output logic [31:0] dat_r,
    output logic        ack,
    input  logic        busy,
    input  logic        nack_event,
    output logic        req_valid,
    output lcd_req_u    req_word,
    output logic        backlight,
    output logic [6:0]  target_addr,
    input  logic        req_ready
);

    logic access;
    logic req_wr;
    logic ctrl_wr;
    logic stat_wr;
    logic nack_err;

    // ack blocks a second hit while stb is still high
    assign access = cyc && stb && !ack;
    assign req_wr = we && (adr == `LCD_I2C_REG_REQ);

    assign ctrl_wr = access && we && (adr == `LCD_I2C_REG_CTRL);
    assign stat_wr = access && we && (adr == `LCD_I2C_REG_STAT);

    assign req_valid = access && req_wr;
    assign req_word  = dat_w[15:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= access && (!req_wr || req_ready); // request writes wait for the sequencer
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            backlight   <= 1'b0;
            target_addr <= `LCD_I2C_DEF_ADDR;
        end else if (ctrl_wr) begin
            backlight   <= dat_w[0];
            target_addr <= dat_w[14:8];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nack_err <= 1'b0;
        end else if (nack_event) begin
            nack_err <= 1'b1; // set wins over clear
        end else if (stat_wr && dat_w[1]) begin
            nack_err <= 1'b0;
        end
    end

    always_comb begin
        dat_r = 32'd0;
        case (adr)
            `LCD_I2C_REG_STAT: dat_r = {30'd0, nack_err, busy};
            `LCD_I2C_REG_CTRL: dat_r = {17'd0, target_addr, 7'd0, backlight};
            default:           dat_r = 32'd0;
        endcase
    end

endmodule

// File: verilog/lcd_i2c_pkg.sv
package lcd_i2c_pkg;

    // kind = 1
    typedef struct packed {
        logic       kind;
        logic [1:0] unused;
        logic [3:0] column;
        logic       line;
        logic [7:0] code;
    } lcd_char_t;

    // kind = 0
    typedef struct packed {
        logic       kind;
        logic [5:0] unused;
        logic       rs;
        logic [7:0] data;
    } lcd_raw_t;

    // low half of the request word, bit 15 picks the view
    typedef union packed {
        lcd_char_t chr;
        lcd_raw_t  raw;
    } lcd_req_u;

    typedef enum logic [2:0] {
        I2C_IDLE,
        I2C_START,
        I2C_SHIFT,
        I2C_ACK,
        I2C_STOP
    } i2c_state_e;

endpackage

// File: verilog/lcd_i2c_config.svh
`ifndef LCD_I2C_CONFIG_SVH
`define LCD_I2C_CONFIG_SVH

// clk cycles per quarter of an scl period
`define LCD_I2C_CLK_DIV 4

// pcf8574 style backpack
`define LCD_I2C_DEF_ADDR 7'h27

`define LCD_I2C_REG_REQ 2'd0
`define LCD_I2C_REG_STAT 2'd1
`define LCD_I2C_REG_CTRL 2'd2

`endif
